//--- verilog/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // divider for the 16x baud tick, 50 MHz / (9600 * 16) - 1
    localparam int div_width = 11;

    typedef logic [div_width-1:0] div_t;

    localparam div_t baud_div = 11'd325;

    // oversampling
    typedef logic [4:0] ovs_t;

    localparam ovs_t ovs_rate        = 5'd16; // ticks per bit
    localparam ovs_t ovs_limit       = 5'd17; // no-edge end of a bit period
    localparam ovs_t sample_majority = 5'd8;  // high count must exceed this

    // frame
    localparam int data_bits = 8;

    typedef logic [data_bits-1:0] byte_t;
    typedef logic [3:0]           bitcnt_t;

    typedef enum logic [1:0] {
        tx_idle,
        tx_start_bit,
        tx_data,
        tx_stop_bit
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_hunt,      // wait for start edge
        rx_frame,     // start bit plus data bits
        rx_wait_idle  // stop bit, line back high
    } rx_state_t;

endpackage

`default_nettype wire

//--- verilog/uart_baud_gen.sv
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
    input  wire  clk,
    input  wire  rst_n,
    output logic baud_tick
);

    uart_pkg::div_t count;

    // free-running down-counter, reloads at zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (count == '0) begin
            count <= uart_pkg::baud_div;
        end else begin
            count <= count - 1'b1;
        end
    end

    // first tick right out of reset
    assign baud_tick = (count == '0);

endmodule

`default_nettype wire

//--- verilog/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    baud_tick,
    input  wire                    rx,
    output uart_pkg::byte_t        data,
    output logic                   valid
);

    logic [1:0]          hist;
    logic                rise;
    logic                fall;
    logic                bit_end;
    logic                bit_val;
    uart_pkg::ovs_t      tick_cnt;
    uart_pkg::ovs_t      high_cnt;
    uart_pkg::bitcnt_t   bit_cnt;
    uart_pkg::byte_t     shreg;
    uart_pkg::rx_state_t state;

    // line history, also the input synchroniser
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hist <= 2'b11;
        end else begin
            hist <= {hist[0], rx};
        end
    end

    assign rise = (hist == 2'b01);
    assign fall = (hist == 2'b10);

    // any edge resyncs the bit period, otherwise it ends at the limit
    assign bit_end = rise || fall || (tick_cnt == uart_pkg::ovs_limit);
    assign bit_val = (high_cnt > uart_pkg::sample_majority);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
            high_cnt <= '0;
        end else if (bit_end) begin
            tick_cnt <= '0;
            high_cnt <= '0;
        end else if (baud_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
            if (hist[0]) begin
                high_cnt <= high_cnt + 1'b1; // count high samples
            end
        end
    end

    // start bit goes in first and drops out the bottom
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_frame && bit_end) begin
            shreg <= {bit_val, shreg[uart_pkg::data_bits-1:1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= uart_pkg::rx_hunt;
            bit_cnt <= '0;
            valid   <= 1'b0;
            data    <= '0;
        end else begin
            valid <= 1'b0;
            case (state)
                uart_pkg::rx_hunt: begin
                    if (fall) begin
                        state   <= uart_pkg::rx_frame;
                        bit_cnt <= '0;
                    end
                end
                uart_pkg::rx_frame: begin
                    if (bit_end) begin
                        // period 0 is the start bit, then data_bits more
                        if (bit_cnt == uart_pkg::bitcnt_t'(uart_pkg::data_bits)) begin
                            data  <= {bit_val, shreg[uart_pkg::data_bits-1:1]};
                            valid <= 1'b1;
                            state <= uart_pkg::rx_wait_idle;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::rx_wait_idle: begin
                    if (hist[0]) begin
                        state <= uart_pkg::rx_hunt; // stop bit seen
                    end
                end
                default: begin
                    state <= uart_pkg::rx_hunt;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  baud_tick,
    input  wire uart_pkg::byte_t data,
    input  wire                  start,
    output logic                 line,
    output logic                 busy
);

    uart_pkg::tx_state_t state;
    uart_pkg::ovs_t      tick_cnt;
    uart_pkg::bitcnt_t   bit_cnt;
    uart_pkg::byte_t     shreg;
    logic                bit_done;
    logic                load;
    logic                shift;

    assign bit_done = baud_tick && (tick_cnt == uart_pkg::ovs_rate - 5'd1);
    assign load     = (state == uart_pkg::tx_idle) && start;
    assign shift    = bit_done && (state == uart_pkg::tx_start_bit ||
                                   state == uart_pkg::tx_data);

    assign busy = (state != uart_pkg::tx_idle);

    always_ff @(posedge clk) begin
        if (load) begin
            shreg <= data;
        end else if (shift) begin
            shreg <= shreg >> 1; // lsb first
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= uart_pkg::tx_idle;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            line     <= 1'b1;
        end else begin
            case (state)
                uart_pkg::tx_idle: begin
                    line <= 1'b1;
                    if (start) begin
                        state <= uart_pkg::tx_start_bit;
                    end
                end
                uart_pkg::tx_start_bit: begin
                    if (baud_tick && line) begin
                        line     <= 1'b0; // start bit on the first tick
                        tick_cnt <= '0;
                    end else if (bit_done) begin
                        line     <= shreg[0];
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= uart_pkg::tx_data;
                    end else if (baud_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_data: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        if (bit_cnt == uart_pkg::bitcnt_t'(uart_pkg::data_bits - 1)) begin
                            line  <= 1'b1;
                            state <= uart_pkg::tx_stop_bit;
                        end else begin
                            line    <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else if (baud_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                uart_pkg::tx_stop_bit: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        state    <= uart_pkg::tx_idle; // busy drops here
                    end else if (baud_tick) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::tx_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/uart.sv
`timescale 1ns/1ps
`default_nettype none

module uart (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  rx,
    output wire                  tx,
    output wire uart_pkg::byte_t rx_data,
    output wire                  rx_valid,
    input  wire uart_pkg::byte_t tx_data,
    input  wire                  tx_start,
    output wire                  tx_busy
);

    wire baud_tick; // shared 16x tick

    uart_baud_gen i_baud (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick)
    );

    uart_rx i_rx (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .rx        (rx),
        .data      (rx_data),
        .valid     (rx_valid)
    );

    uart_tx i_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_tick (baud_tick),
        .data      (tx_data),
        .start     (tx_start),
        .line      (tx),
        .busy      (tx_busy)
    );

endmodule

`default_nettype wire

//--- bench/uart_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int tick_clks = 326;            // 50 MHz / (9600 * 16)
    localparam int bit_clks  = tick_clks * 16; // 5216 clocks per bit
    localparam int max_ops   = 64;

    logic       clk;
    logic       rst_n;
    logic       rx;
    wire        tx;
    wire  [7:0] rx_data;
    wire        rx_valid;
    logic [7:0] tx_data;
    logic       tx_start;
    wire        tx_busy;

    logic [11:0] vectors [0:max_ops-1];
    logic [7:0]  rx_queue [$];
    int          err_cnt     = 0;
    int          timeout_cnt = 0;
    int          valid_cnt   = 0;
    int          expected_rx = 0;
    int          cycle       = 0;

    uart i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .tx       (tx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_busy  (tx_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // collect every received byte
    always @(negedge clk) begin
        if (rx_valid === 1'b1) begin
            valid_cnt++;
            rx_queue.push_back(rx_data);
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %0h, got %0h at %0t", name, expected, actual, $time);
            err_cnt++;
        end
    endtask

    task automatic drive_bit(input logic b);
        @(posedge clk);
        #2;
        rx = b;
        repeat (bit_clks - 1) @(posedge clk);
    endtask

    task automatic send_frame(input logic [7:0] b);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(b[i]); // lsb first
        end
        drive_bit(1'b1);
    endtask

    task automatic receive_byte(input logic [7:0] b);
        int         waited;
        logic [7:0] got;
        waited = 0;
        expected_rx++;
        send_frame(b);
        // frame took 10 bits, allow 2 more
        while (valid_cnt < expected_rx && waited < 2 * bit_clks) begin
            @(posedge clk);
            waited++;
        end
        if (valid_cnt < expected_rx) begin
            $display("timeout: rx_valid did not pulse within 12 bit times for byte %h", b);
            timeout_cnt++;
        end else begin
            compare("rx_valid count", expected_rx, valid_cnt);
            got = rx_queue.pop_front();
            compare("rx_data", b, got);
        end
    endtask

    task automatic pulse_start(input logic [7:0] b);
        @(posedge clk);
        #2;
        tx_data  = b;
        tx_start = 1'b1;
        @(posedge clk);
        #2;
        tx_start = 1'b0;
    endtask

    task automatic watch_tx_frame(input logic [7:0] b);
        int         waited;
        logic [7:0] got;
        waited = 0;
        @(negedge clk);
        while (tx !== 1'b0 && waited < bit_clks) begin
            @(negedge clk);
            waited++;
        end
        if (tx !== 1'b0) begin
            $display("timeout: no start bit appeared on tx for byte %h", b);
            timeout_cnt++;
        end else begin
            repeat (bit_clks / 2) @(negedge clk); // middle of start bit
            compare("tx start bit", 0, tx);
            for (int i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge clk);
                got[i] = tx;
            end
            compare("tx data", b, got);
            repeat (bit_clks) @(negedge clk);
            compare("tx stop bit", 1, tx);
        end
    endtask

    task automatic wait_busy_low(input int start_cycle);
        int waited;
        waited = 0;
        while (tx_busy !== 1'b0 && waited < 2 * bit_clks) begin
            @(negedge clk);
            waited++;
        end
        if (tx_busy !== 1'b0) begin
            $display("timeout: tx_busy did not fall after the stop bit");
            timeout_cnt++;
        end else if (cycle - start_cycle > 11 * bit_clks) begin
            $display("tx_busy fell %0d clocks after tx_start, later than 11 bit times",
                     cycle - start_cycle);
            err_cnt++;
        end
    endtask

    task automatic transmit_byte(input logic [7:0] b, input logic restart);
        int start_cycle;
        int low_seen;
        low_seen = 0;
        pulse_start(b);
        start_cycle = cycle;
        @(negedge clk);
        compare("tx_busy", 1, tx_busy);
        fork
            watch_tx_frame(b);
            begin
                if (restart) begin
                    repeat (3 * bit_clks) @(negedge clk);
                    compare("tx_busy", 1, tx_busy);
                    pulse_start(~b); // must be dropped
                end
            end
        join
        wait_busy_low(start_cycle);
        if (restart) begin
            repeat (2 * bit_clks) begin
                @(negedge clk);
                if (tx !== 1'b1) begin
                    low_seen = 1;
                end
            end
            if (low_seen) begin
                $display("a second frame started on tx after a tx_start while busy");
                err_cnt++;
            end
            compare("tx_busy", 0, tx_busy);
        end
    endtask

    task automatic check_reset_outputs();
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            compare("tx", 1, tx);
            compare("tx_busy", 0, tx_busy);
            compare("rx_valid", 0, rx_valid);
        end
        compare("rx_data", 0, rx_data);
    endtask

    initial begin
        int         op_idx;
        logic       done;
        logic [3:0] opcode;
        logic [7:0] value;
        rst_n    = 1'b0;
        rx       = 1'b1;
        tx_data  = 8'h00;
        tx_start = 1'b0;
        op_idx   = 0;
        done     = 1'b0;
        for (int i = 0; i < max_ops; i++) begin
            vectors[i] = 12'h000;
        end
        $readmemh("bench/uart_vectors.txt", vectors);

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_reset_outputs();

        while (!done && op_idx < max_ops) begin
            opcode = vectors[op_idx][11:8];
            value  = vectors[op_idx][7:0];
            case (opcode)
                4'h0: done = 1'b1;
                4'h1: receive_byte(value);
                4'h2: transmit_byte(value, 1'b0);
                4'h3: transmit_byte(value, 1'b1);
                default: begin
                    $display("unknown opcode %h in vector %0d", opcode, op_idx);
                    err_cnt++;
                end
            endcase
            op_idx++;
        end

        // no stray strobes after the last frame
        repeat (2 * bit_clks) @(posedge clk);
        compare("rx_valid count", expected_rx, valid_cnt);

        $display("errors: %0d, timeouts: %0d", err_cnt, timeout_cnt);
        if (err_cnt == 0 && timeout_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/uart_vectors.txt
// one hex word per line: opcode nibble, then data byte
// 1 = receive on rx, 2 = transmit on tx, 3 = transmit with a second start while busy, 0 = end
100
1ff
155
1a5
2a5
200
2ff
13c
1c3
181
17e
255
33c
3c3
1a5
15a
2c3
300
1ff
100
000

//--- project.f
verilog/uart_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart.sv
bench/uart_tb.sv

//--- run.sh
#!/bin/sh
# build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    --top-module uart_tb \
    -f project.f \
    -Mdir obj_dir -o uart_sim

./obj_dir/uart_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
